// File: common/an_pkg.sv
// Clause 37 constants, full duplex only; next page and pause bits are placed but never advertised
package an_pkg;

   // Configuration word bit positions
   localparam int NP_BIT  = 15;  // Next page
   localparam int ACK_BIT = 14;  // Acknowledge
   localparam int RF2_BIT = 13;  // Remote fault, upper
   localparam int RF1_BIT = 12;  // Remote fault, lower
   localparam int PS2_BIT = 8;   // Asymmetric pause
   localparam int PS1_BIT = 7;   // Symmetric pause
   localparam int HD_BIT  = 6;   // Half duplex
   localparam int FD_BIT  = 5;   // Full duplex

   // Arbitration states
   // Numeric order is meaningful, watchdog reads a higher code as progress
   localparam logic [2:0] AN_RESTART = 3'd0;
   localparam logic [2:0] AN_ABILITY = 3'd1;
   localparam logic [2:0] AN_ACK     = 3'd2;
   localparam logic [2:0] AN_IDLE    = 3'd3;
   localparam logic [2:0] AN_LINK_OK = 3'd4;
   localparam logic [2:0] AN_ABORT   = 3'd5;

   // an_status bit positions
   localparam int ST_LINK_OK      = 0;
   localparam int ST_IDLE         = 1;
   localparam int ST_ACK          = 2;
   localparam int ST_ABL_MISMATCH = 3;  // Partner lacks full duplex
   localparam int ST_RF1          = 4;
   localparam int ST_RF2          = 5;
   localparam int ST_WDOG_DIS     = 6;  // Renegotiation disabled by watchdog
   localparam int ST_ABILITY      = 7;
   localparam int ST_ABORT        = 8;

   // Width of an_status
   localparam int ST_WIDTH = 9;

endpackage

// File: common/an_rx_if.sv
// Receive-side flags, all synchronous to rx_clk; breaklink_seen is a single-cycle pulse
interface an_rx_if;

   logic       link_det;           // Any config word since last los
   logic       abl_match;          // Sticky, ability word seen
   logic       ack_match;          // Sticky, acknowledged word seen
   logic       consistency_match;  // Acked word equals latched ability
   logic       breaklink_seen;     // Three zero words in a row
   logic [1:0] remote_fault;       // {RF2, RF1} of latest word
   logic       abl_mismatch;       // Partner ability without FD

   // Decoder drives everything
   modport decode (
      output link_det, abl_match, ack_match, consistency_match,
             breaklink_seen, remote_fault, abl_mismatch
   );

   // Arbiter and result block only read
   modport arbiter (
      input link_det, abl_match, ack_match, consistency_match,
            breaklink_seen, remote_fault, abl_mismatch
   );

endinterface

// File: common/an_ctl_if.sv
// Arbiter state and next-cycle transmit levels, synchronous to rx_clk, unregistered
interface an_ctl_if;

   logic [2:0] state;           // Current arbitration state
   logic       send_ack;        // Set ACK in transmitted word
   logic       send_breaklink;  // Transmit all-zero word
   logic       lacr_send_n;     // Config words on the line next cycle
   logic       operate_n;       // Upper layers enabled next cycle
   logic       wdog_disable;    // Watchdog gave up, next restart aborts

   modport arbiter (
      output state, send_ack, send_breaklink, lacr_send_n, operate_n, wdog_disable
   );

   // Decoder only needs the state to qualify its flags
   modport decode (
      input state
   );

   modport result (
      input state, send_ack, send_breaklink, lacr_send_n, operate_n, wdog_disable
   );

endinterface

// File: negotiate/an_cfg_decode.sv
// Config word decoder; every lacr_in_stb is consumed, no next page or idle ordered-set checks
module an_cfg_decode import an_pkg::*; (
   input  logic        rx_clk,
   input  logic        an_rst,
   input  logic        los,
   input  logic [15:0] lacr_in,
   input  logic        lacr_in_stb,
   an_rx_if.decode     rx,
   an_ctl_if.decode    ctl
);

   logic [15:0] lacr_prev;     // Last received word
   logic [15:0] lacr_ability;  // Ability word, ACK forced high
   logic        lacr_match;
   logic        lacr_change;
   logic [1:0]  match_cnt;
   logic [1:0]  zero_cnt;
   logic        in_restart;
   logic        match_ok;
   logic        abl_latch;

   assign in_restart = (ctl.state == AN_RESTART);
   assign match_ok   = (match_cnt == 2'd3);  // Four identical words in a row

   // Ability word accepted only while detecting ability and without ACK
   assign abl_latch = (ctl.state == AN_ABILITY) && match_ok && !lacr_prev[ACK_BIT];

   // Link presence with los taking priority
   always_ff @(posedge rx_clk) begin
      if (an_rst || los)
         rx.link_det <= 1'b0;
      else if (lacr_in_stb)
         rx.link_det <= 1'b1;
   end

   // Matcher held idle during restart so each attempt starts fresh
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         lacr_prev   <= '0;
         lacr_match  <= 1'b0;
         lacr_change <= 1'b0;
         match_cnt   <= '0;
      end else if (in_restart) begin
         lacr_match  <= 1'b0;
         lacr_change <= 1'b0;
         match_cnt   <= '0;  // Previous word kept
      end else begin
         if (lacr_in_stb)
            lacr_prev <= lacr_in;
         lacr_match  <= lacr_in_stb && (lacr_in == lacr_prev);
         lacr_change <= lacr_in_stb && (lacr_in != lacr_prev);
         if (lacr_change || match_ok || rx.breaklink_seen)
            match_cnt <= '0;
         else if (lacr_match)
            match_cnt <= match_cnt + 2'd1;
      end
   end

   // Sticky ability and ack flags dropped whenever arbitration restarts
   always_ff @(posedge rx_clk) begin
      if (an_rst || in_restart) begin
         rx.abl_match         <= 1'b0;
         rx.ack_match         <= 1'b0;
         rx.consistency_match <= 1'b0;
      end else begin
         if (abl_latch)
            rx.abl_match <= 1'b1;
         if ((ctl.state == AN_ACK) && match_ok && lacr_prev[ACK_BIT]) begin
            rx.ack_match         <= 1'b1;
            // Same edge as ack_match so arbiter never sees a stale result
            rx.consistency_match <= (lacr_ability == lacr_prev);
         end
      end
   end

   // Latched partner ability
   always_ff @(posedge rx_clk) begin
      if (abl_latch) begin
         lacr_ability          <= lacr_prev;
         lacr_ability[ACK_BIT] <= 1'b1;  // Compared against acked copy
      end
   end

   // Full duplex missing from last accepted ability
   always_ff @(posedge rx_clk) begin
      if (an_rst)
         rx.abl_mismatch <= 1'b0;
      else if (abl_latch)
         rx.abl_mismatch <= !lacr_prev[FD_BIT];
   end

   // One breaklink pulse per three zero words
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         zero_cnt          <= '0;
         rx.breaklink_seen <= 1'b0;
      end else begin
         rx.breaklink_seen <= 1'b0;
         if (lacr_in_stb) begin
            if (lacr_in != 16'd0) begin
               zero_cnt <= '0;
            end else if (zero_cnt == 2'd2) begin
               zero_cnt          <= '0;
               rx.breaklink_seen <= 1'b1;
            end else begin
               zero_cnt <= zero_cnt + 2'd1;
            end
         end
      end
   end

   assign rx.remote_fault = {lacr_prev[RF2_BIT], lacr_prev[RF1_BIT]};

   // Ability only ever accepted in ability detect
   a_abl_in_ability : assert property (@(posedge rx_clk) disable iff (an_rst)
      $rose(rx.abl_match) |-> ($past(ctl.state) == AN_ABILITY));

endmodule

// File: negotiate/an_arbiter.sv
// Clause 37 arbitration on rx_clk; idle detect always passes, watchdog stall leads to abort
module an_arbiter import an_pkg::*; #(
   parameter int TIMER_TICKS = 1250000,  // Link timer, rx_clk cycles
   parameter int WDOG_MULT   = 8          // Watchdog in link timer units
) (
   input  logic       rx_clk,
   input  logic       an_rst,
   input  logic       los,
   an_rx_if.arbiter   rx,
   an_ctl_if.arbiter  ctl
);

   localparam int TMR_W      = $clog2(TIMER_TICKS + 1);
   localparam int WDOG_LIMIT = TIMER_TICKS * WDOG_MULT;
   localparam int WDOG_W     = $clog2(WDOG_LIMIT + 1);

   logic [2:0]        state;
   logic [2:0]        state_nxt;    // FSM choice
   logic [2:0]        state_d;      // After forced restarts
   logic              restart_req;
   logic              state_chg;
   logic [TMR_W-1:0]  tmr_cnt;
   logic              tmr_on;
   logic              tmr_used;     // Already started in this state
   logic              tmr_expired;  // Level until state changes
   logic              tmr_start;
   logic [WDOG_W-1:0] wdog_cnt;
   logic              wdog_disable;
   logic              wdog_run;
   logic              wdog_timeout;
   logic              progress;

   assign restart_req = (rx.breaklink_seen && !wdog_disable) || los || wdog_timeout;
   assign state_d     = restart_req ? AN_RESTART : state_nxt;
   assign state_chg   = (state_d != state);

   always_ff @(posedge rx_clk) begin
      if (an_rst)
         state <= AN_RESTART;
      else
         state <= state_d;
   end

   always_comb begin
      state_nxt          = state;
      tmr_start          = 1'b0;
      ctl.lacr_send_n    = 1'b0;
      ctl.send_ack       = 1'b0;
      ctl.send_breaklink = 1'b0;
      ctl.operate_n      = 1'b0;
      case (state)
         AN_RESTART: begin
            ctl.lacr_send_n    = 1'b1;
            ctl.send_breaklink = 1'b1;
            tmr_start          = !tmr_used;
            if (tmr_expired && rx.link_det)
               state_nxt = wdog_disable ? AN_ABORT : AN_ABILITY;
         end
         AN_ABILITY: begin
            ctl.lacr_send_n = 1'b1;
            if (rx.abl_match)
               state_nxt = AN_ACK;
         end
         AN_ACK: begin
            ctl.lacr_send_n = 1'b1;
            ctl.send_ack    = 1'b1;
            tmr_start       = !tmr_used;
            if (tmr_expired && rx.ack_match)
               state_nxt = rx.consistency_match ? AN_IDLE : AN_RESTART;
         end
         AN_IDLE: begin
            ctl.send_ack = 1'b1;  // Late PCS words still carry ACK
            tmr_start    = !tmr_used;
            if (tmr_expired)      // Idle match assumed
               state_nxt = AN_LINK_OK;
         end
         AN_LINK_OK: begin
            ctl.send_ack  = 1'b1;
            ctl.operate_n = 1'b1;
         end
         default: begin        // Abort, run without negotiation
            ctl.operate_n = 1'b1;
         end
      endcase
   end

   // One-shot link timer, expires TIMER_TICKS edges after start
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         tmr_cnt     <= '0;
         tmr_on      <= 1'b0;
         tmr_used    <= 1'b0;
         tmr_expired <= 1'b0;
      end else if (state_chg) begin
         tmr_on      <= 1'b0;  // Rearm for new state
         tmr_used    <= 1'b0;
         tmr_expired <= 1'b0;
      end else if (tmr_start) begin
         tmr_cnt  <= TMR_W'(TIMER_TICKS - 1);
         tmr_on   <= 1'b1;
         tmr_used <= 1'b1;
      end else if (tmr_on) begin
         if (tmr_cnt == '0) begin
            tmr_on      <= 1'b0;
            tmr_expired <= 1'b1;
         end else begin
            tmr_cnt <= tmr_cnt - 1'b1;
         end
      end
   end

   // Watchdog; leaving restart is not progress so restart loops accumulate
   assign wdog_run     = rx.link_det && (state != AN_LINK_OK) && !wdog_disable;
   assign wdog_timeout = wdog_run && (wdog_cnt == WDOG_W'(WDOG_LIMIT - 1));
   assign progress     = (state_d > state) && (state != AN_RESTART);

   always_ff @(posedge rx_clk) begin
      if (an_rst || progress || los) begin
         wdog_cnt     <= '0;
         wdog_disable <= 1'b0;
      end else if (wdog_timeout) begin
         wdog_cnt     <= '0;   // Single pulse, otherwise restart would stick
         wdog_disable <= 1'b1;
      end else if (wdog_run) begin
         wdog_cnt <= wdog_cnt + 1'b1;
      end
   end

   assign ctl.state        = state;
   assign ctl.wdog_disable = wdog_disable;

   a_state_legal : assert property (@(posedge rx_clk) disable iff (an_rst)
      state <= AN_ABORT);

   // Used flag must keep the timer from retriggering mid-count
   a_tmr_one_shot : assert property (@(posedge rx_clk) disable iff (an_rst)
      tmr_start |-> !tmr_on);

endmodule

// File: negotiate/an_cfg_result.sv
// Registered transmit word and status; advertises full duplex only, no pause or remote fault
module an_cfg_result import an_pkg::*; (
   input  logic                rx_clk,
   input  logic                an_rst,
   an_ctl_if.result            ctl,
   an_rx_if.arbiter            rx,
   output logic [15:0]         lacr_out,
   output logic                lacr_send,
   output logic                operate,
   output logic [ST_WIDTH-1:0] an_status
);

   logic [15:0]         cfg_word;
   logic [ST_WIDTH-1:0] status_d;

   // Local ability word
   always_comb begin
      cfg_word          = '0;        // Reserved bits zero
      cfg_word[FD_BIT]  = 1'b1;
      cfg_word[HD_BIT]  = 1'b0;
      cfg_word[PS1_BIT] = 1'b0;      // No pause
      cfg_word[PS2_BIT] = 1'b0;
      cfg_word[RF1_BIT] = 1'b0;      // Never report a local fault
      cfg_word[RF2_BIT] = 1'b0;
      cfg_word[ACK_BIT] = ctl.send_ack;
      cfg_word[NP_BIT]  = 1'b0;
   end

   always_comb begin
      status_d                  = '0;
      status_d[ST_LINK_OK]      = (ctl.state == AN_LINK_OK);
      status_d[ST_IDLE]         = (ctl.state == AN_IDLE);
      status_d[ST_ACK]          = (ctl.state == AN_ACK);
      status_d[ST_ABL_MISMATCH] = rx.abl_mismatch;
      status_d[ST_RF1]          = rx.remote_fault[0];
      status_d[ST_RF2]          = rx.remote_fault[1];
      status_d[ST_WDOG_DIS]     = ctl.wdog_disable;
      status_d[ST_ABILITY]      = (ctl.state == AN_ABILITY);
      status_d[ST_ABORT]        = (ctl.state == AN_ABORT);
   end

   // One register stage on every output
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         lacr_out  <= '0;        // Breaklink word
         lacr_send <= 1'b1;
         operate   <= 1'b0;
         an_status <= '0;
      end else begin
         lacr_out  <= ctl.send_breaklink ? 16'd0 : cfg_word;
         lacr_send <= ctl.lacr_send_n;
         operate   <= ctl.operate_n;
         an_status <= status_d;
      end
   end

endmodule

// File: hw/pcs_an_top.sv
// Auto-negotiation top, single rx_clk domain, lacr_in_stb never stalled, full duplex only
module pcs_an_top #(
   parameter int TIMER_TICKS = 1250000,  // 10 ms at 125 MHz
   parameter int WDOG_MULT   = 8
) (
   input  logic        rx_clk,
   input  logic        an_rst,       // Synchronous, active high
   input  logic        los,          // Loss of signal
   input  logic [15:0] lacr_in,      // Decoded partner word
   input  logic        lacr_in_stb,
   output logic [15:0] lacr_out,     // Word to transmit
   output logic        lacr_send,    // Transmit config words, not idles
   output logic        operate,      // Link usable by upper layers
   output logic [8:0]  an_status
);

   an_rx_if  rx_bus ();
   an_ctl_if ctl_bus ();

   an_cfg_decode u_decode (
      .rx_clk      (rx_clk),
      .an_rst      (an_rst),
      .los         (los),
      .lacr_in     (lacr_in),
      .lacr_in_stb (lacr_in_stb),
      .rx          (rx_bus.decode),
      .ctl         (ctl_bus.decode)
   );

   an_arbiter #(
      .TIMER_TICKS (TIMER_TICKS),
      .WDOG_MULT   (WDOG_MULT)
   ) u_arbiter (
      .rx_clk (rx_clk),
      .an_rst (an_rst),
      .los    (los),
      .rx     (rx_bus.arbiter),
      .ctl    (ctl_bus.arbiter)
   );

   an_cfg_result u_result (
      .rx_clk    (rx_clk),
      .an_rst    (an_rst),
      .ctl       (ctl_bus.result),
      .rx        (rx_bus.arbiter),
      .lacr_out  (lacr_out),
      .lacr_send (lacr_send),
      .operate   (operate),
      .an_status (an_status)
   );

endmodule

// File: dv/tb_pcs_an.sv
// Rows run back to back with a 24-cycle link timer and each starts where the last left the FSM
module tb_pcs_an import an_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int TICKS    = 24;
   localparam int WDOG_X   = 8;
   localparam int CLK_HALF = 50;  // 100 ns period
   localparam int DRV_DLY  = 5;   // Input skew after rising edge

   // Partner and local config words
   localparam logic [15:0] FD_W    = 16'h1 << FD_BIT;
   localparam logic [15:0] ACK_W   = 16'h1 << ACK_BIT;
   localparam logic [15:0] NO_FD_W = (16'h1 << RF2_BIT) | (16'h1 << RF1_BIT) | (16'h1 << HD_BIT);

   // Status masks
   localparam logic [8:0] S_LINK  = 9'h1 << ST_LINK_OK;
   localparam logic [8:0] S_IDLE  = 9'h1 << ST_IDLE;
   localparam logic [8:0] S_ACK   = 9'h1 << ST_ACK;
   localparam logic [8:0] S_MIS   = 9'h1 << ST_ABL_MISMATCH;
   localparam logic [8:0] S_RF1   = 9'h1 << ST_RF1;
   localparam logic [8:0] S_RF2   = 9'h1 << ST_RF2;
   localparam logic [8:0] S_WDOG  = 9'h1 << ST_WDOG_DIS;
   localparam logic [8:0] S_ABL   = 9'h1 << ST_ABILITY;
   localparam logic [8:0] S_ABORT = 9'h1 << ST_ABORT;
   localparam logic [8:0] S_STATE = S_LINK | S_IDLE | S_ACK | S_ABL | S_ABORT;  // Restart shows none
   localparam logic [8:0] S_ALL   = 9'h1ff;

   logic        rx_clk;
   logic        an_rst;
   logic        los;
   logic [15:0] lacr_in;
   logic        lacr_in_stb;
   logic [15:0] lacr_out;
   logic        lacr_send;
   logic        operate;
   logic [8:0]  an_status;
   int          run_limit;  // Zero until the table is built

   // Stimulus table with one entry per row in each queue
   string       t_name[$];
   logic [15:0] t_word[$];   // Partner word
   int          t_count[$];  // Words to send
   int          t_gap[$];    // Cycles between strobes
   logic        t_los[$];
   logic [8:0]  t_mask[$];   // Status bits to wait on
   logic [8:0]  t_stat[$];   // Their expected value
   int          t_bound[$];  // Max cycles of that wait
   logic [15:0] t_out[$];
   logic        t_send[$];
   logic        t_oper[$];

   pcs_an_top #(
      .TIMER_TICKS (TICKS),
      .WDOG_MULT   (WDOG_X)
   ) uut (
      .rx_clk      (rx_clk),
      .an_rst      (an_rst),
      .los         (los),
      .lacr_in     (lacr_in),
      .lacr_in_stb (lacr_in_stb),
      .lacr_out    (lacr_out),
      .lacr_send   (lacr_send),
      .operate     (operate),
      .an_status   (an_status)
   );

   initial rx_clk = 1'b0;
   always #CLK_HALF rx_clk = ~rx_clk;

   task automatic abort_run();
      $display("FAIL: see errors above");
      $fatal(1, "run stopped");
   endtask

   task automatic check_equal(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      if (expected !== actual) begin
         $display("error: %s expected %h actual %h", name, expected, actual);
         abort_run();
      end
   endtask

   task automatic add_row(input string name, input logic [15:0] word, input int count,
                          input int gap, input logic los_lvl, input logic [8:0] mask,
                          input logic [8:0] stat, input int bound, input logic [15:0] out,
                          input logic send, input logic oper);
      t_name.push_back(name);
      t_word.push_back(word);
      t_count.push_back(count);
      t_gap.push_back(gap);
      t_los.push_back(los_lvl);
      t_mask.push_back(mask);
      t_stat.push_back(stat);
      t_bound.push_back(bound);
      t_out.push_back(out);
      t_send.push_back(send);
      t_oper.push_back(oper);
   endtask

   // Partner model sends one strobe per word then gap-1 quiet cycles
   task automatic send_words(input logic [15:0] word, input int count, input int gap);
      if (count == 0) begin  // Quiet line for gap-1 cycles
         repeat (gap - 1) begin
            @(posedge rx_clk);
            #DRV_DLY;
         end
      end
      for (int i = 0; i < count; i++) begin
         lacr_in     = word;
         lacr_in_stb = 1'b1;
         @(posedge rx_clk);
         #DRV_DLY;
         lacr_in_stb = 1'b0;
         repeat (gap - 1) begin
            @(posedge rx_clk);
            #DRV_DLY;
         end
      end
   endtask

   // Bounded wait on masked status sampled just after the drive point
   task automatic wait_status(input string name, input logic [8:0] mask,
                              input logic [8:0] stat, input int bound);
      int waited;
      waited = 0;
      while (((an_status & mask) !== stat) && (waited < bound)) begin
         @(posedge rx_clk);
         #DRV_DLY;
         waited++;
      end
      check_equal({name, " status wait"}, 16'(stat), 16'(an_status & mask));
   endtask

   task automatic build_table();
      //      name                word           cnt gap los mask    status  bound
      add_row("after_reset",      16'h0000,       0, 1, 1'b0, S_ALL, 9'h000,  4,
              16'h0000, 1'b1, 1'b0);
      add_row("ability_detect",   FD_W,          28, 2, 1'b0, S_STATE, S_ACK, 80,
              FD_W | ACK_W, 1'b1, 1'b0);
      add_row("link_up",          FD_W | ACK_W,  16, 1, 1'b0, S_STATE, S_LINK, 80,
              FD_W | ACK_W, 1'b0, 1'b1);
      add_row("breaklink",        16'h0000,       3, 1, 1'b0, S_STATE, 9'h000, 10,
              16'h0000, 1'b1, 1'b0);
      add_row("relink_quiet",     16'h0000,       0, 1, 1'b0, S_STATE, S_ABL, 40,
              FD_W, 1'b1, 1'b0);
      add_row("los_restart",      16'h0000,       0, 1, 1'b1, S_STATE, 9'h000, 6,
              16'h0000, 1'b1, 1'b0);
      // Silent partner past a full link timer keeps the FSM in restart
      add_row("los_release",      16'h0000,       0, TICKS + 16, 1'b0, S_STATE, 9'h000, 4,
              16'h0000, 1'b1, 1'b0);
      // Partner ability without FD and with both RF bits
      add_row("no_fd_ability",    NO_FD_W,       40, 1, 1'b0, S_STATE | S_MIS | S_RF1 | S_RF2,
              S_ACK | S_MIS | S_RF1 | S_RF2, 60, FD_W | ACK_W, 1'b1, 1'b0);
      add_row("inconsistent_ack", FD_W | ACK_W,   8, 1, 1'b0, S_STATE, 9'h000, 60,
              16'h0000, 1'b1, 1'b0);
      // Stuck in ability with no words until the DUT watchdog fires
      add_row("watchdog_disable", 16'h0000,       0, 1, 1'b0, S_STATE | S_WDOG, S_WDOG, 300,
              16'h0000, 1'b1, 1'b0);
      add_row("watchdog_abort",   16'h0000,       0, 1, 1'b0, S_STATE | S_WDOG,
              S_ABORT | S_WDOG, 60, FD_W, 1'b0, 1'b1);
      add_row("los_in_abort",     16'h0000,       0, 1, 1'b1, S_STATE | S_WDOG, 9'h000, 6,
              16'h0000, 1'b1, 1'b0);
   endtask

   // Run limit from the table in clock cycles
   initial begin
      wait (run_limit > 0);
      repeat (run_limit) @(posedge rx_clk);
      $display("Timeout, run went past %0d clock cycles", run_limit);
      abort_run();
   end

   initial begin
      int total;
      an_rst      = 1'b1;
      los         = 1'b0;
      lacr_in     = 16'h0000;
      lacr_in_stb = 1'b0;
      build_table();
      total = 3 + 50;  // Reset plus margin
      for (int r = 0; r < t_name.size(); r++)
         total += ((t_count[r] > 0) ? t_count[r] : 1) * t_gap[r] + t_bound[r];
      run_limit = total;
      repeat (3) @(posedge rx_clk);
      #DRV_DLY;
      an_rst = 1'b0;
      for (int r = 0; r < t_name.size(); r++) begin
         los = t_los[r];
         fork
            send_words(t_word[r], t_count[r], t_gap[r]);
            wait_status(t_name[r], t_mask[r], t_stat[r], t_bound[r]);
         join
         // Status must still hold once the partner has gone quiet
         check_equal({t_name[r], " status"}, 16'(t_stat[r]), 16'(an_status & t_mask[r]));
         check_equal({t_name[r], " lacr_out"}, t_out[r], lacr_out);
         check_equal({t_name[r], " lacr_send"}, 16'(t_send[r]), 16'(lacr_send));
         check_equal({t_name[r], " operate"}, 16'(t_oper[r]), 16'(operate));
      end
      $display("PASS: all tests");
      $finish;
   end

endmodule

// File: verilog.f
common/an_pkg.sv
common/an_rx_if.sv
common/an_ctl_if.sv
negotiate/an_cfg_decode.sv
negotiate/an_arbiter.sv
negotiate/an_cfg_result.sv
hw/pcs_an_top.sv
dv/tb_pcs_an.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_pcs_an
RTL_TOP  = pcs_an_top
FILELIST = verilog.f
LOG      = sim.log
BIN      = obj_dir/V$(TOP)
FAIL_MSG = FAIL: see errors above
PASS_MSG = PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
